/* angle_pkg.sv */
// shared widths, Q12.4 constants and rate limits; limits assume 4 fraction bits and 16-bit rates
package angle_pkg;

	// receiver stick value, unsigned
	localparam int rec_width = 8;

	// Q12.4 rate and angle word
	localparam int rate_width = 16;

	// working width for the mapping step
	localparam int ops_width = 24;

	// width of a per-axis scale shift amount
	localparam int shift_width = 4;

	// fraction bits of a Q12.4 word
	localparam int fixed_point_shift = 4;

	// largest legal stick value from the receiver
	localparam int rec_max = 250;

	// stick * 4 spans 0 to 1000, so 500 centres it at +/- 31.25 deg
	localparam int mapping_offset = 500;

	// throttle limits, 0.0 to 250.0
	localparam int throttle_min = 0;
	localparam int throttle_max = 250 << fixed_point_shift;

	// yaw, pitch and roll limits, +/- 100.0
	localparam int axis_max = 100 << fixed_point_shift;
	localparam int axis_min = -(100 << fixed_point_shift);

endpackage

/* setpoint_capture.sv */
// one-entry input register; stick values above 250 are clamped, data must hold while cmd_valid is high
`timescale 1ns/1ps

module setpoint_capture (
	input  logic                                       us_clk,
	input  logic                                       resetn,
	input  logic                                       cmd_valid,
	output logic                                       cmd_ready,
	input  logic        [angle_pkg::rec_width-1:0]     throttle_target,
	input  logic        [angle_pkg::rec_width-1:0]     yaw_target,
	input  logic        [angle_pkg::rec_width-1:0]     pitch_target,
	input  logic        [angle_pkg::rec_width-1:0]     roll_target,
	input  logic signed [angle_pkg::rate_width-1:0]    pitch_actual,
	input  logic signed [angle_pkg::rate_width-1:0]    roll_actual,
	output logic                                       sample_valid,
	input  logic                                       sample_ready,
	output logic        [angle_pkg::rec_width-1:0]     sample_throttle,
	output logic        [angle_pkg::rec_width-1:0]     sample_yaw,
	output logic        [angle_pkg::rec_width-1:0]     sample_pitch,
	output logic        [angle_pkg::rec_width-1:0]     sample_roll,
	output logic signed [angle_pkg::rate_width-1:0]    sample_pitch_actual,
	output logic signed [angle_pkg::rate_width-1:0]    sample_roll_actual
);

	logic full;
	logic run;
	logic take;

	// a receiver glitch above full deflection would widen the mapped range
	function automatic logic [angle_pkg::rec_width-1:0] clamp_stick(
		input logic [angle_pkg::rec_width-1:0] stick);
		if (stick > angle_pkg::rec_max)
			return angle_pkg::rec_width'(angle_pkg::rec_max);
		return stick;
	endfunction

	// ready also when the held sample leaves this cycle
	assign cmd_ready    = run && (!full || sample_ready);
	assign take         = cmd_valid && cmd_ready;
	assign sample_valid = full;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			run  <= 1'b0;
			full <= 1'b0;
		end else begin
			// opens the input one cycle after reset release
			run <= 1'b1;
			if (take)
				full <= 1'b1;
			else if (sample_ready)
				full <= 1'b0;
		end
	end

	always_ff @(posedge us_clk) begin
		if (take) begin
			sample_throttle     <= clamp_stick(throttle_target);
			sample_yaw          <= clamp_stick(yaw_target);
			sample_pitch        <= clamp_stick(pitch_target);
			sample_roll         <= clamp_stick(roll_target);
			sample_pitch_actual <= pitch_actual;
			sample_roll_actual  <= roll_actual;
		end
	end

endmodule

/* angle_controller.sv */
// three-stage map/scale/limit pipeline, 3-cycle latency; stalls as a whole and saturates angle errors to 16 bits
`timescale 1ns/1ps

module angle_controller #(
	parameter int                                yaw_scale_mult       = 5,
	parameter logic [angle_pkg::shift_width-1:0] yaw_scale_shift      = 1,
	parameter int                                pitch_scale_mult     = 3,
	parameter logic [angle_pkg::shift_width-1:0] pitch_scale_shift    = 0,
	parameter int                                roll_scale_mult      = 3,
	parameter logic [angle_pkg::shift_width-1:0] roll_scale_shift     = 0,
	parameter int                                throttle_scale_mult  = 1,
	parameter logic [angle_pkg::shift_width-1:0] throttle_scale_shift = 0
) (
	input  logic                                    us_clk,
	input  logic                                    resetn,
	input  logic                                    sample_valid,
	output logic                                    sample_ready,
	input  logic        [angle_pkg::rec_width-1:0]  sample_throttle,
	input  logic        [angle_pkg::rec_width-1:0]  sample_yaw,
	input  logic        [angle_pkg::rec_width-1:0]  sample_pitch,
	input  logic        [angle_pkg::rec_width-1:0]  sample_roll,
	input  logic signed [angle_pkg::rate_width-1:0] sample_pitch_actual,
	input  logic signed [angle_pkg::rate_width-1:0] sample_roll_actual,
	output logic                                    result_valid,
	input  logic                                    result_ready,
	output logic signed [angle_pkg::rate_width-1:0] throttle_rate,
	output logic signed [angle_pkg::rate_width-1:0] yaw_rate,
	output logic signed [angle_pkg::rate_width-1:0] pitch_rate,
	output logic signed [angle_pkg::rate_width-1:0] roll_rate,
	output logic signed [angle_pkg::rate_width-1:0] pitch_angle_error,
	output logic signed [angle_pkg::rate_width-1:0] roll_angle_error
);

	localparam int rw       = angle_pkg::rate_width;
	localparam int ow       = angle_pkg::ops_width;
	localparam int word_max = (1 << (rw - 1)) - 1;
	localparam int word_min = -(1 << (rw - 1));

	logic advance;
	logic map_valid, scale_valid, limit_valid;

	// stage 1 mapped values
	logic signed [ow-1:0] map_throttle, map_yaw, map_pitch, map_roll;

	// stage 2 scaled values and carried pitch/roll errors
	logic signed [rw-1:0] scl_throttle, scl_yaw, scl_pitch, scl_roll;
	logic signed [ow-1:0] err_pitch, err_roll;

	// stick 0..250 to -500..500 in Q12.4
	function automatic logic signed [ow-1:0] center_stick(
		input logic [angle_pkg::rec_width-1:0] stick);
		logic signed [ow-1:0] wide;
		wide = $signed({{(ow - angle_pkg::rec_width){1'b0}}, stick});
		return (wide <<< 2) - ow'(angle_pkg::mapping_offset);
	endfunction

	function automatic logic signed [rw-1:0] sat_word(input logic signed [31:0] v);
		if (v > word_max)
			return rw'(word_max);
		else if (v < word_min)
			return rw'(word_min);
		return v[rw-1:0];
	endfunction

	// (val * mult) >>> shift in 32 bits, then saturate
	function automatic logic signed [rw-1:0] scale_sat(
		input logic signed [ow-1:0]                val,
		input int                                  mult,
		input logic [angle_pkg::shift_width-1:0]   shift);
		logic signed [31:0] wide;
		logic signed [31:0] prod;
		wide = val;
		prod = (wide * mult) >>> shift;
		return sat_word(prod);
	endfunction

	function automatic logic signed [rw-1:0] limit_rate(
		input logic signed [rw-1:0] v,
		input int                   lo,
		input int                   hi);
		if (v > hi)
			return rw'(hi);
		else if (v < lo)
			return rw'(lo);
		return v;
	endfunction

	// whole pipeline moves together
	assign advance      = !limit_valid || result_ready;
	assign sample_ready = advance;
	assign result_valid = limit_valid;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			map_valid   <= 1'b0;
			scale_valid <= 1'b0;
			limit_valid <= 1'b0;
		end else if (advance) begin
			map_valid   <= sample_valid;
			scale_valid <= map_valid;
			limit_valid <= scale_valid;
		end
	end

	always_ff @(posedge us_clk) begin
		if (advance) begin
			// mapping
			map_throttle <= $signed({{(ow - angle_pkg::rec_width){1'b0}}, sample_throttle})
				<<< angle_pkg::fixed_point_shift;
			map_yaw      <= center_stick(sample_yaw);
			// IMU roll sign is flipped, so it is added
			map_roll     <= center_stick(sample_roll) + sample_roll_actual;
			map_pitch    <= center_stick(sample_pitch) - sample_pitch_actual;

			// scaling
			scl_throttle <= scale_sat(map_throttle, throttle_scale_mult, throttle_scale_shift);
			scl_yaw      <= scale_sat(map_yaw, yaw_scale_mult, yaw_scale_shift);
			scl_pitch    <= scale_sat(map_pitch, pitch_scale_mult, pitch_scale_shift);
			scl_roll     <= scale_sat(map_roll, roll_scale_mult, roll_scale_shift);
			err_pitch    <= map_pitch;
			err_roll     <= map_roll;

			// limiting
			throttle_rate <= limit_rate(scl_throttle, angle_pkg::throttle_min,
				angle_pkg::throttle_max);
			yaw_rate      <= limit_rate(scl_yaw, angle_pkg::axis_min, angle_pkg::axis_max);
			pitch_rate    <= limit_rate(scl_pitch, angle_pkg::axis_min, angle_pkg::axis_max);
			roll_rate     <= limit_rate(scl_roll, angle_pkg::axis_min, angle_pkg::axis_max);
			// large IMU angles can exceed the 16-bit error word
			pitch_angle_error <= sat_word(err_pitch);
			roll_angle_error  <= sat_word(err_roll);
		end
	end

endmodule

/* rate_command_buffer.sv */
// two-entry FIFO of finished commands; out data holds while out_valid is high, no write when full
`timescale 1ns/1ps

module rate_command_buffer (
	input  logic                                    us_clk,
	input  logic                                    resetn,
	input  logic                                    result_valid,
	output logic                                    result_ready,
	input  logic signed [angle_pkg::rate_width-1:0] result_throttle_rate,
	input  logic signed [angle_pkg::rate_width-1:0] result_yaw_rate,
	input  logic signed [angle_pkg::rate_width-1:0] result_pitch_rate,
	input  logic signed [angle_pkg::rate_width-1:0] result_roll_rate,
	input  logic signed [angle_pkg::rate_width-1:0] result_pitch_angle_error,
	input  logic signed [angle_pkg::rate_width-1:0] result_roll_angle_error,
	output logic                                    out_valid,
	input  logic                                    out_ready,
	output logic signed [angle_pkg::rate_width-1:0] out_throttle_rate,
	output logic signed [angle_pkg::rate_width-1:0] out_yaw_rate,
	output logic signed [angle_pkg::rate_width-1:0] out_pitch_rate,
	output logic signed [angle_pkg::rate_width-1:0] out_roll_rate,
	output logic signed [angle_pkg::rate_width-1:0] out_pitch_angle_error,
	output logic signed [angle_pkg::rate_width-1:0] out_roll_angle_error
);

	localparam int rw = angle_pkg::rate_width;

	// six words per entry, throttle in the top word
	logic [6*rw-1:0] mem [0:1];
	logic [6*rw-1:0] rd_entry;
	logic            wr_ptr, rd_ptr;
	logic [1:0]      count;
	logic            push, pop;

	assign result_ready = (count < 2'd2);
	assign out_valid    = (count != 2'd0);
	assign push         = result_valid && result_ready;
	assign pop          = out_valid && out_ready;

	assign rd_entry              = mem[rd_ptr];
	assign out_throttle_rate     = rd_entry[6*rw-1:5*rw];
	assign out_yaw_rate          = rd_entry[5*rw-1:4*rw];
	assign out_pitch_rate        = rd_entry[4*rw-1:3*rw];
	assign out_roll_rate         = rd_entry[3*rw-1:2*rw];
	assign out_pitch_angle_error = rd_entry[2*rw-1:rw];
	assign out_roll_angle_error  = rd_entry[rw-1:0];

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	always_ff @(posedge us_clk) begin
		if (push)
			mem[wr_ptr] <= {result_throttle_rate, result_yaw_rate, result_pitch_rate,
				result_roll_rate, result_pitch_angle_error, result_roll_angle_error};
	end

endmodule

/* attitude_command_top.sv */
// attitude command front end, 5-cycle latency at one sample per cycle; scale defaults suit the stock airframe
`timescale 1ns/1ps

module attitude_command_top #(
	parameter int                                yaw_scale_mult       = 5,
	parameter logic [angle_pkg::shift_width-1:0] yaw_scale_shift      = 1,
	parameter int                                pitch_scale_mult     = 3,
	parameter logic [angle_pkg::shift_width-1:0] pitch_scale_shift    = 0,
	parameter int                                roll_scale_mult      = 3,
	parameter logic [angle_pkg::shift_width-1:0] roll_scale_shift     = 0,
	parameter int                                throttle_scale_mult  = 1,
	parameter logic [angle_pkg::shift_width-1:0] throttle_scale_shift = 0
) (
	input  logic                                    us_clk,
	input  logic                                    resetn,
	input  logic                                    cmd_valid,
	output logic                                    cmd_ready,
	input  logic        [angle_pkg::rec_width-1:0]  throttle_target,
	input  logic        [angle_pkg::rec_width-1:0]  yaw_target,
	input  logic        [angle_pkg::rec_width-1:0]  pitch_target,
	input  logic        [angle_pkg::rec_width-1:0]  roll_target,
	input  logic signed [angle_pkg::rate_width-1:0] pitch_actual,
	input  logic signed [angle_pkg::rate_width-1:0] roll_actual,
	output logic                                    out_valid,
	input  logic                                    out_ready,
	output logic signed [angle_pkg::rate_width-1:0] throttle_rate,
	output logic signed [angle_pkg::rate_width-1:0] yaw_rate,
	output logic signed [angle_pkg::rate_width-1:0] pitch_rate,
	output logic signed [angle_pkg::rate_width-1:0] roll_rate,
	output logic signed [angle_pkg::rate_width-1:0] pitch_angle_error,
	output logic signed [angle_pkg::rate_width-1:0] roll_angle_error
);

	// capture to controller
	logic                                    sample_valid, sample_ready;
	logic        [angle_pkg::rec_width-1:0]  sample_throttle, sample_yaw;
	logic        [angle_pkg::rec_width-1:0]  sample_pitch, sample_roll;
	logic signed [angle_pkg::rate_width-1:0] sample_pitch_actual, sample_roll_actual;

	// controller to buffer
	logic                                    result_valid, result_ready;
	logic signed [angle_pkg::rate_width-1:0] result_throttle_rate, result_yaw_rate;
	logic signed [angle_pkg::rate_width-1:0] result_pitch_rate, result_roll_rate;
	logic signed [angle_pkg::rate_width-1:0] result_pitch_angle_error, result_roll_angle_error;

	setpoint_capture setpoint_capture_inst (
		.us_clk              (us_clk),
		.resetn              (resetn),
		.cmd_valid           (cmd_valid),
		.cmd_ready           (cmd_ready),
		.throttle_target     (throttle_target),
		.yaw_target          (yaw_target),
		.pitch_target        (pitch_target),
		.roll_target         (roll_target),
		.pitch_actual        (pitch_actual),
		.roll_actual         (roll_actual),
		.sample_valid        (sample_valid),
		.sample_ready        (sample_ready),
		.sample_throttle     (sample_throttle),
		.sample_yaw          (sample_yaw),
		.sample_pitch        (sample_pitch),
		.sample_roll         (sample_roll),
		.sample_pitch_actual (sample_pitch_actual),
		.sample_roll_actual  (sample_roll_actual)
	);

	angle_controller #(
		.yaw_scale_mult       (yaw_scale_mult),
		.yaw_scale_shift      (yaw_scale_shift),
		.pitch_scale_mult     (pitch_scale_mult),
		.pitch_scale_shift    (pitch_scale_shift),
		.roll_scale_mult      (roll_scale_mult),
		.roll_scale_shift     (roll_scale_shift),
		.throttle_scale_mult  (throttle_scale_mult),
		.throttle_scale_shift (throttle_scale_shift)
	) angle_controller_inst (
		.us_clk              (us_clk),
		.resetn              (resetn),
		.sample_valid        (sample_valid),
		.sample_ready        (sample_ready),
		.sample_throttle     (sample_throttle),
		.sample_yaw          (sample_yaw),
		.sample_pitch        (sample_pitch),
		.sample_roll         (sample_roll),
		.sample_pitch_actual (sample_pitch_actual),
		.sample_roll_actual  (sample_roll_actual),
		.result_valid        (result_valid),
		.result_ready        (result_ready),
		.throttle_rate       (result_throttle_rate),
		.yaw_rate            (result_yaw_rate),
		.pitch_rate          (result_pitch_rate),
		.roll_rate           (result_roll_rate),
		.pitch_angle_error   (result_pitch_angle_error),
		.roll_angle_error    (result_roll_angle_error)
	);

	rate_command_buffer rate_command_buffer_inst (
		.us_clk                   (us_clk),
		.resetn                   (resetn),
		.result_valid             (result_valid),
		.result_ready             (result_ready),
		.result_throttle_rate     (result_throttle_rate),
		.result_yaw_rate          (result_yaw_rate),
		.result_pitch_rate        (result_pitch_rate),
		.result_roll_rate         (result_roll_rate),
		.result_pitch_angle_error (result_pitch_angle_error),
		.result_roll_angle_error  (result_roll_angle_error),
		.out_valid                (out_valid),
		.out_ready                (out_ready),
		.out_throttle_rate        (throttle_rate),
		.out_yaw_rate             (yaw_rate),
		.out_pitch_rate           (pitch_rate),
		.out_roll_rate            (roll_rate),
		.out_pitch_angle_error    (pitch_angle_error),
		.out_roll_angle_error     (roll_angle_error)
	);

endmodule

/* attitude_command_checker.sv */
// handshake and rate range assertions for the top level, bound by port name; assumes default rate limits
`timescale 1ns/1ps

module attitude_command_checker (
	input logic               us_clk,
	input logic               resetn,
	input logic               cmd_valid,
	input logic               cmd_ready,
	input logic [7:0]         throttle_target,
	input logic [7:0]         yaw_target,
	input logic [7:0]         pitch_target,
	input logic [7:0]         roll_target,
	input logic signed [15:0] pitch_actual,
	input logic signed [15:0] roll_actual,
	input logic               out_valid,
	input logic               out_ready,
	input logic signed [15:0] throttle_rate,
	input logic signed [15:0] yaw_rate,
	input logic signed [15:0] pitch_rate,
	input logic signed [15:0] roll_rate,
	input logic signed [15:0] pitch_angle_error,
	input logic signed [15:0] roll_angle_error
);

	logic [63:0] cmd_data;
	logic [95:0] out_data;

	assign cmd_data = {throttle_target, yaw_target, pitch_target, roll_target,
		pitch_actual, roll_actual};
	assign out_data = {throttle_rate, yaw_rate, pitch_rate, roll_rate,
		pitch_angle_error, roll_angle_error};

	// a stalled command must hold
	assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
		else $error("command input changed while stalled");

	assert property (@(posedge us_clk) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("rate output changed while stalled");

	assert property (@(posedge us_clk) !resetn |-> !out_valid)
		else $error("out_valid high during reset");

	// throttle 0 to 250.0, other axes +/- 100.0
	assert property (@(posedge us_clk) disable iff (!resetn)
		out_valid |-> throttle_rate >= 0 && throttle_rate <= 4000)
		else $error("throttle rate out of range");

	assert property (@(posedge us_clk) disable iff (!resetn)
		out_valid |-> yaw_rate >= -1600 && yaw_rate <= 1600
			&& pitch_rate >= -1600 && pitch_rate <= 1600
			&& roll_rate >= -1600 && roll_rate <= 1600)
		else $error("axis rate out of range");

endmodule

bind attitude_command_top attitude_command_checker attitude_command_checker_inst (.*);

/* tb_attitude_command.sv */
// directed testbench, default scale parameters; expected results come from a local model
`timescale 1ns/1ps

module tb_attitude_command;

	// about 800 cycles of traffic plus reset, with wide margin
	localparam int cycle_limit = 4000;

	logic        us_clk;
	logic        resetn;
	logic        cmd_valid;
	logic        cmd_ready;
	logic [7:0]  throttle_target, yaw_target, pitch_target, roll_target;
	logic signed [15:0] pitch_actual, roll_actual;
	logic        out_valid;
	logic        out_ready;
	logic signed [15:0] throttle_rate, yaw_rate, pitch_rate, roll_rate;
	logic signed [15:0] pitch_angle_error, roll_angle_error;

	logic [95:0] exp_q[$];
	logic [95:0] exp_word;
	int          accept_q[$];
	int          accept_cycle;
	string       test_name;
	int          fail_count;
	int          cycles;
	int          ready_mode;
	int          ready_cnt;

	attitude_command_top attitude_command_top_inst (.*);

	initial begin
		us_clk = 1'b0;
		forever #20 us_clk = ~us_clk;
	end

	function automatic int clip(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	function automatic int scale_axis(input int v, input int mult, input int shift);
		return clip((v * mult) >>> shift, -32768, 32767);
	endfunction

	// sticks clamp to 250, centre at 500 in Q12.4, IMU roll adds and pitch subtracts
	function automatic logic [95:0] predict_command(input int t, input int y, input int p,
		input int r, input int pa, input int ra);
		int m_t, m_y, m_p, m_r;
		int thr, yaw, pit, rol;
		m_t = clip(t, 0, 250) * 16;
		m_y = clip(y, 0, 250) * 4 - 500;
		m_p = clip(p, 0, 250) * 4 - 500 - pa;
		m_r = clip(r, 0, 250) * 4 - 500 + ra;
		thr = clip(scale_axis(m_t, 1, 0), 0, 4000);
		yaw = clip(scale_axis(m_y, 5, 1), -1600, 1600);
		pit = clip(scale_axis(m_p, 3, 0), -1600, 1600);
		rol = clip(scale_axis(m_r, 3, 0), -1600, 1600);
		return {16'(thr), 16'(yaw), 16'(pit), 16'(rol),
			16'(clip(m_p, -32768, 32767)), 16'(clip(m_r, -32768, 32767))};
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			fail_count++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
			$display("tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// hold the sample until accepted, then log its expected result
	task automatic send_sample(input logic [7:0] t, input logic [7:0] y, input logic [7:0] p,
		input logic [7:0] r, input logic signed [15:0] pa, input logic signed [15:0] ra);
		logic accepted;
		cmd_valid       = 1'b1;
		throttle_target = t;
		yaw_target      = y;
		pitch_target    = p;
		roll_target     = r;
		pitch_actual    = pa;
		roll_actual     = ra;
		// cmd_ready only moves on the rising edge, so this value holds for the next one
		accepted = cmd_ready;
		@(posedge us_clk);
		while (!accepted) begin
			@(negedge us_clk);
			accepted = cmd_ready;
			@(posedge us_clk);
		end
		exp_q.push_back(predict_command(t, y, p, r, pa, ra));
		accept_q.push_back(cycles);
		@(negedge us_clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge us_clk);
	endtask

	task automatic test_neutral();
		test_name = "neutral";
		send_sample(8'd0, 8'd125, 8'd125, 8'd125, 16'sd0, 16'sd0);
		send_sample(8'd60, 8'd125, 8'd125, 8'd125, 16'sd0, 16'sd0);
		send_sample(8'd125, 8'd125, 8'd125, 8'd125, 16'sd0, 16'sd0);
		send_sample(8'd200, 8'd125, 8'd125, 8'd125, 16'sd0, 16'sd0);
		send_sample(8'd250, 8'd125, 8'd125, 8'd125, 16'sd0, 16'sd0);
		wait_drain();
	endtask

	task automatic test_saturation();
		test_name = "saturation";
		send_sample(8'd250, 8'd250, 8'd250, 8'd250, 16'sd0, 16'sd0);
		send_sample(8'd0, 8'd0, 8'd0, 8'd0, 16'sd0, 16'sd0);
		send_sample(8'd125, 8'd125, 8'd125, 8'd125, 16'sd1000, -16'sd1000);
		send_sample(8'd125, 8'd125, 8'd0, 8'd250, -16'sd32768, 16'sd32767);
		wait_drain();
	endtask

	task automatic test_imu();
		test_name = "imu_correction";
		send_sample(8'd125, 8'd125, 8'd125, 8'd125, 16'sd80, -16'sd48);
		send_sample(8'd125, 8'd125, 8'd125, 8'd125, -16'sd200, 16'sd150);
		send_sample(8'd125, 8'd125, 8'd125, 8'd125, 16'sd533, -16'sd533);
		wait_drain();
	endtask

	task automatic test_sanitise();
		test_name = "sanitise";
		for (int v = 251; v <= 255; v++) begin
			send_sample(8'(v), 8'(v), 8'(v), 8'(v), 16'sd0, 16'sd0);
			send_sample(8'd250, 8'd250, 8'd250, 8'd250, 16'sd0, 16'sd0);
		end
		wait_drain();
	endtask

	task automatic test_backpressure();
		test_name = "backpressure";
		ready_mode = 2;
		for (int i = 0; i < 10; i++)
			send_sample(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom),
				16'($urandom_range(0, 1023)) - 16'sd512,
				16'($urandom_range(0, 1023)) - 16'sd512);
		wait_drain();
		ready_mode = 0;
	endtask

	task automatic test_random();
		test_name = "random_stream";
		ready_mode = 1;
		for (int i = 0; i < 200; i++) begin
			if ($urandom_range(0, 3) == 0)
				@(negedge us_clk);
			send_sample(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom),
				16'($urandom), 16'($urandom));
		end
		wait_drain();
		ready_mode = 0;
	endtask

	// mode 0 holds out_ready high, mode 1 toggles it at random, mode 2 holds it low 12 of 15 cycles
	always @(negedge us_clk) begin
		ready_cnt++;
		case (ready_mode)
			1: out_ready = 1'($urandom_range(0, 1));
			2: out_ready = ((ready_cnt % 15) >= 12);
			default: out_ready = 1'b1;
		endcase
	end

	always @(posedge us_clk) begin
		if (resetn && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("an output was delivered with no sample pending in test %s", test_name);
				$display("tests failed");
				$fatal(1, "unexpected output");
			end else begin
				exp_word     = exp_q.pop_front();
				accept_cycle = accept_q.pop_front();
				// with out_ready held high nothing stalls
				if (ready_mode == 0)
					check_value("latency", 5, cycles - accept_cycle);
				check_value("throttle_rate", $signed(exp_word[95:80]), throttle_rate);
				check_value("yaw_rate", $signed(exp_word[79:64]), yaw_rate);
				check_value("pitch_rate", $signed(exp_word[63:48]), pitch_rate);
				check_value("roll_rate", $signed(exp_word[47:32]), roll_rate);
				check_value("pitch_angle_error", $signed(exp_word[31:16]), pitch_angle_error);
				check_value("roll_angle_error", $signed(exp_word[15:0]), roll_angle_error);
			end
		end
	end

	always @(negedge us_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("the run did not finish within %0d cycles", cycle_limit);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(32'he23bd7bc));
		resetn          = 1'b0;
		cmd_valid       = 1'b0;
		throttle_target = 8'd0;
		yaw_target      = 8'd0;
		pitch_target    = 8'd0;
		roll_target     = 8'd0;
		pitch_actual    = 16'sd0;
		roll_actual     = 16'sd0;
		out_ready       = 1'b1;
		ready_mode      = 0;
		ready_cnt       = 0;
		fail_count      = 0;
		cycles          = 0;
		test_name       = "reset";
		repeat (16)
			@(negedge us_clk);
		check_value("cmd_ready", 0, cmd_ready);
		resetn = 1'b1;
		@(negedge us_clk);
		// input opens in the first cycle after release
		check_value("cmd_ready", 1, cmd_ready);
		test_neutral();
		test_saturation();
		test_imu();
		test_sanitise();
		test_backpressure();
		test_random();
		repeat (4)
			@(negedge us_clk);
		if (fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "mismatches were reported");
		end
	end

endmodule

/* filelist.f */
angle_pkg.sv
setpoint_capture.sv
angle_controller.sv
rate_command_buffer.sv
attitude_command_top.sv
attitude_command_checker.sv
tb_attitude_command.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = tb_attitude_command
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
